/* logic/cp0_exc_unit.sv */
`timescale 1ns/10ps

module cp0_exc_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                we_i,
    input  cp0_pkg::cp0_addr_t  waddr_i,
    input  cp0_pkg::cp0_word_t  wdata_i,
    input  cp0_pkg::exc_type_t  except_type_i,
    input  cp0_pkg::cp0_word_t  pc_i,
    input  cp0_pkg::cp0_word_t  mem_addr_i,
    input  logic                in_delay_slot_i,
    input  cp0_pkg::cp0_word_t  status_i,
    exc_commit_if.master        commit,
    output cp0_pkg::cp0_word_t  epc_o,
    output cp0_pkg::cp0_word_t  badvaddr_o
);
    import cp0_pkg::*;

    logic      exl;
    logic      take_d;
    logic      eret_d;
    logic      rewrite_epc;
    logic      fetch_err;
    logic      mem_err;
    exc_code_t code_d;
    cp0_word_t epc_new;
    logic      epc_we;

    assign exl    = status_i[STATUS_EXL_BIT];
    assign epc_we = we_i && (waddr_i == ADDR_EPC);

    // Restart at the branch when the fault sits in its delay slot
    assign epc_new = in_delay_slot_i ? (pc_i - 32'd4) : pc_i;

    always_comb begin
        take_d      = 1'b1;
        eret_d      = 1'b0;
        rewrite_epc = ~exl;
        fetch_err   = 1'b0;
        mem_err     = 1'b0;
        code_d      = EXCCODE_INT;

        case (except_type_i)
            EXC_INT: begin
                rewrite_epc = 1'b1;
            end
            EXC_ADEL: begin
                code_d  = EXCCODE_ADEL;
                mem_err = 1'b1;
            end
            EXC_ADES: begin
                code_d  = EXCCODE_ADES;
                mem_err = 1'b1;
            end
            EXC_SYS: code_d = EXCCODE_SYS;
            EXC_BP:  code_d = EXCCODE_BP;
            EXC_RI:  code_d = EXCCODE_RI;
            EXC_OV:  code_d = EXCCODE_OV;
            EXC_TR:  code_d = EXCCODE_TR;
            EXC_IADEL: begin
                // Fetch fault puts the bad PC itself in EPC
                code_d      = EXCCODE_ADEL;
                rewrite_epc = 1'b0;
                fetch_err   = 1'b1;
            end
            EXC_ERET: begin
                take_d      = 1'b0;
                eret_d      = 1'b1;
                rewrite_epc = 1'b0;
            end
            default: begin
                take_d      = 1'b0;
                rewrite_epc = 1'b0;
            end
        endcase
    end

    assign commit.take     = take_d;
    assign commit.exc_code = code_d;
    assign commit.bd_we    = rewrite_epc;
    assign commit.bd       = in_delay_slot_i;
    assign commit.eret     = eret_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            epc_o      <= '0;
            badvaddr_o <= '0;
        end else begin
            if (rewrite_epc) begin
                epc_o <= epc_new;
            end else if (fetch_err) begin
                epc_o <= pc_i;
            end else if (epc_we) begin
                epc_o <= wdata_i;
            end

            if (fetch_err) begin
                badvaddr_o <= pc_i;
            end else if (mem_err) begin
                badvaddr_o <= mem_addr_i;
            end
        end
    end

endmodule

/* logic/cp0_pkg.sv */
package cp0_pkg;

    typedef logic [31:0] cp0_word_t;
    // {register number, select}
    typedef logic [7:0]  cp0_addr_t;
    typedef logic [4:0]  exc_code_t;
    typedef logic [5:0]  int_pins_t;

    // What the pipeline presents this cycle
    typedef enum logic [4:0] {
        EXC_NONE  = 5'd0,
        EXC_INT   = 5'd1,
        EXC_ADEL  = 5'd4,
        EXC_ADES  = 5'd5,
        EXC_SYS   = 5'd8,
        EXC_BP    = 5'd9,
        EXC_RI    = 5'd10,
        EXC_OV    = 5'd12,
        EXC_TR    = 5'd13,
        EXC_ERET  = 5'd14,
        EXC_IADEL = 5'd15
    } exc_type_t;

    localparam cp0_addr_t ADDR_BADVADDR = {5'd8, 3'd0};
    localparam cp0_addr_t ADDR_COUNT    = {5'd9, 3'd0};
    localparam cp0_addr_t ADDR_COMPARE  = {5'd11, 3'd0};
    localparam cp0_addr_t ADDR_STATUS   = {5'd12, 3'd0};
    localparam cp0_addr_t ADDR_CAUSE    = {5'd13, 3'd0};
    localparam cp0_addr_t ADDR_EPC      = {5'd14, 3'd0};
    localparam cp0_addr_t ADDR_PRID     = {5'd15, 3'd0};
    localparam cp0_addr_t ADDR_EBASE    = {5'd15, 3'd1};

    localparam int STATUS_BEV_BIT   = 22;
    localparam int STATUS_EXL_BIT   = 1;
    localparam int CAUSE_BD_BIT     = 31;
    localparam int CAUSE_IV_BIT     = 23;
    localparam int CAUSE_IP_HW_MSB  = 15;
    localparam int CAUSE_IP_HW_LSB  = 10;
    localparam int CAUSE_EXC_MSB    = 6;
    localparam int CAUSE_EXC_LSB    = 2;

    // BEV, IM7..0, EXL, IE
    localparam cp0_word_t STATUS_WMASK = 32'h0040_FF03;
    // IV, WP, IP1..0
    localparam cp0_word_t CAUSE_WMASK  = 32'h00C0_0300;
    localparam cp0_word_t EBASE_WMASK  = 32'h3FFF_F000;
    localparam cp0_word_t STATUS_RESET = 32'h0040_0000;

    localparam exc_code_t EXCCODE_INT  = 5'd0;
    localparam exc_code_t EXCCODE_ADEL = 5'd4;
    localparam exc_code_t EXCCODE_ADES = 5'd5;
    localparam exc_code_t EXCCODE_SYS  = 5'd8;
    localparam exc_code_t EXCCODE_BP   = 5'd9;
    localparam exc_code_t EXCCODE_RI   = 5'd10;
    localparam exc_code_t EXCCODE_OV   = 5'd12;
    localparam exc_code_t EXCCODE_TR   = 5'd13;

    localparam cp0_word_t BEV_VECTOR_BASE = 32'hBFC0_0200;
    localparam cp0_word_t VEC_OFF_GENERAL = 32'h0000_0180;
    localparam cp0_word_t VEC_OFF_INT     = 32'h0000_0200;

endpackage

/* logic/cp0_read_mux.sv */
`timescale 1ns/10ps

module cp0_read_mux #(
    parameter cp0_pkg::cp0_word_t PRID_VALUE = 32'h0001_8000
) (
    input  cp0_pkg::cp0_addr_t  raddr_i,
    input  cp0_pkg::cp0_word_t  count_i,
    input  cp0_pkg::cp0_word_t  compare_i,
    input  cp0_pkg::cp0_word_t  status_i,
    input  cp0_pkg::cp0_word_t  cause_i,
    input  cp0_pkg::cp0_word_t  epc_i,
    input  cp0_pkg::cp0_word_t  badvaddr_i,
    input  cp0_pkg::cp0_word_t  ebase_i,
    output cp0_pkg::cp0_word_t  data_o
);
    import cp0_pkg::*;

    always_comb begin
        case (raddr_i)
            ADDR_BADVADDR: data_o = badvaddr_i;
            ADDR_COUNT:    data_o = count_i;
            ADDR_COMPARE:  data_o = compare_i;
            ADDR_STATUS:   data_o = status_i;
            ADDR_CAUSE:    data_o = cause_i;
            ADDR_EPC:      data_o = epc_i;
            ADDR_PRID:     data_o = PRID_VALUE;
            ADDR_EBASE:    data_o = ebase_i;
            // Unimplemented registers read zero
            default:       data_o = '0;
        endcase
    end

endmodule

/* logic/cp0_status_cause.sv */
`timescale 1ns/10ps

module cp0_status_cause (
    input  logic                clk,
    input  logic                rst,
    input  cp0_pkg::int_pins_t  int_i,
    input  logic                we_i,
    input  cp0_pkg::cp0_addr_t  waddr_i,
    input  cp0_pkg::cp0_word_t  wdata_i,
    exc_commit_if.slave         commit,
    output cp0_pkg::cp0_word_t  status_o,
    output cp0_pkg::cp0_word_t  cause_o
);
    import cp0_pkg::*;

    cp0_word_t status_d;
    cp0_word_t cause_d;
    logic      status_we;
    logic      cause_we;

    assign status_we = we_i && (waddr_i == ADDR_STATUS);
    assign cause_we  = we_i && (waddr_i == ADDR_CAUSE);

    always_comb begin
        status_d = status_o;
        cause_d  = cause_o;

        if (status_we) begin
            status_d = (status_o & ~STATUS_WMASK) | (wdata_i & STATUS_WMASK);
        end
        if (cause_we) begin
            cause_d = (cause_o & ~CAUSE_WMASK) | (wdata_i & CAUSE_WMASK);
        end

        // Hardware pins land in IP7..IP2 every cycle
        cause_d[CAUSE_IP_HW_MSB:CAUSE_IP_HW_LSB] = int_i;

        // Commit overrides a software write to the same field
        if (commit.take) begin
            status_d[STATUS_EXL_BIT]              = 1'b1;
            cause_d[CAUSE_EXC_MSB:CAUSE_EXC_LSB] = commit.exc_code;
            if (commit.bd_we) begin
                cause_d[CAUSE_BD_BIT] = commit.bd;
            end
        end

        if (commit.eret) begin
            status_d[STATUS_EXL_BIT] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            status_o <= STATUS_RESET;
            cause_o  <= '0;
        end else begin
            status_o <= status_d;
            cause_o  <= cause_d;
        end
    end

endmodule

/* logic/cp0_timer.sv */
`timescale 1ns/10ps

module cp0_timer (
    input  logic               clk,
    input  logic               rst,
    input  logic               we_i,
    input  cp0_pkg::cp0_addr_t waddr_i,
    input  cp0_pkg::cp0_word_t wdata_i,
    output cp0_pkg::cp0_word_t count_o,
    output cp0_pkg::cp0_word_t compare_o,
    output logic               timer_int_o
);
    import cp0_pkg::*;

    logic count_we;
    logic compare_we;
    logic match;

    assign count_we   = we_i && (waddr_i == ADDR_COUNT);
    assign compare_we = we_i && (waddr_i == ADDR_COMPARE);
    assign match      = (compare_o != '0) && (count_o == compare_o);

    always_ff @(posedge clk) begin
        if (rst) begin
            count_o     <= '0;
            compare_o   <= '0;
            timer_int_o <= 1'b0;
        end else begin
            if (count_we) begin
                count_o <= wdata_i;
            end else begin
                count_o <= count_o + 32'd1;
            end

            // Sticky until software rewrites Compare
            if (compare_we) begin
                compare_o   <= wdata_i;
                timer_int_o <= 1'b0;
            end else if (match) begin
                timer_int_o <= 1'b1;
            end
        end
    end

endmodule

/* logic/cp0_top.sv */
`timescale 1ns/10ps

module cp0_top #(
    parameter cp0_pkg::cp0_word_t PRID_VALUE  = 32'h0001_8000,
    parameter cp0_pkg::cp0_word_t EBASE_RESET = 32'h8000_0000
) (
    input  logic                clk,
    input  logic                rst,
    input  cp0_pkg::int_pins_t  int_i,
    input  logic                we_i,
    input  cp0_pkg::cp0_addr_t  waddr_i,
    input  cp0_pkg::cp0_addr_t  raddr_i,
    input  cp0_pkg::cp0_word_t  wdata_i,
    input  cp0_pkg::exc_type_t  except_type_i,
    input  cp0_pkg::cp0_word_t  pc_i,
    input  cp0_pkg::cp0_word_t  mem_addr_i,
    input  logic                in_delay_slot_i,
    output cp0_pkg::cp0_word_t  data_o,
    output cp0_pkg::cp0_word_t  exc_vector_o,
    output cp0_pkg::cp0_word_t  status_o,
    output cp0_pkg::cp0_word_t  cause_o,
    output cp0_pkg::cp0_word_t  epc_o,
    output logic                timer_int_o
);
    import cp0_pkg::*;

    cp0_word_t count;
    cp0_word_t compare;
    cp0_word_t badvaddr;
    cp0_word_t ebase;

    exc_commit_if u_commit ();

    cp0_timer u_timer (
        .clk         (clk),
        .rst         (rst),
        .we_i        (we_i),
        .waddr_i     (waddr_i),
        .wdata_i     (wdata_i),
        .count_o     (count),
        .compare_o   (compare),
        .timer_int_o (timer_int_o)
    );

    cp0_status_cause u_status_cause (
        .clk      (clk),
        .rst      (rst),
        .int_i    (int_i),
        .we_i     (we_i),
        .waddr_i  (waddr_i),
        .wdata_i  (wdata_i),
        .commit   (u_commit.slave),
        .status_o (status_o),
        .cause_o  (cause_o)
    );

    cp0_exc_unit u_exc_unit (
        .clk             (clk),
        .rst             (rst),
        .we_i            (we_i),
        .waddr_i         (waddr_i),
        .wdata_i         (wdata_i),
        .except_type_i   (except_type_i),
        .pc_i            (pc_i),
        .mem_addr_i      (mem_addr_i),
        .in_delay_slot_i (in_delay_slot_i),
        .status_i        (status_o),
        .commit          (u_commit.master),
        .epc_o           (epc_o),
        .badvaddr_o      (badvaddr)
    );

    cp0_vector #(
        .EBASE_RESET (EBASE_RESET)
    ) u_vector (
        .clk           (clk),
        .rst           (rst),
        .we_i          (we_i),
        .waddr_i       (waddr_i),
        .wdata_i       (wdata_i),
        .except_type_i (except_type_i),
        .status_i      (status_o),
        .cause_i       (cause_o),
        .epc_i         (epc_o),
        .ebase_o       (ebase),
        .exc_vector_o  (exc_vector_o)
    );

    cp0_read_mux #(
        .PRID_VALUE (PRID_VALUE)
    ) u_read_mux (
        .raddr_i    (raddr_i),
        .count_i    (count),
        .compare_i  (compare),
        .status_i   (status_o),
        .cause_i    (cause_o),
        .epc_i      (epc_o),
        .badvaddr_i (badvaddr),
        .ebase_i    (ebase),
        .data_o     (data_o)
    );

endmodule

/* logic/cp0_vector.sv */
`timescale 1ns/10ps

module cp0_vector #(
    parameter cp0_pkg::cp0_word_t EBASE_RESET = 32'h8000_0000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                we_i,
    input  cp0_pkg::cp0_addr_t  waddr_i,
    input  cp0_pkg::cp0_word_t  wdata_i,
    input  cp0_pkg::exc_type_t  except_type_i,
    input  cp0_pkg::cp0_word_t  status_i,
    input  cp0_pkg::cp0_word_t  cause_i,
    input  cp0_pkg::cp0_word_t  epc_i,
    output cp0_pkg::cp0_word_t  ebase_o,
    output cp0_pkg::cp0_word_t  exc_vector_o
);
    import cp0_pkg::*;

    cp0_word_t vec_base;
    cp0_word_t vec_off;

    always_ff @(posedge clk) begin
        if (rst) begin
            ebase_o <= EBASE_RESET;
        end else if (we_i && (waddr_i == ADDR_EBASE)) begin
            ebase_o <= (ebase_o & ~EBASE_WMASK) | (wdata_i & EBASE_WMASK);
        end
    end

    always_comb begin
        vec_base = status_i[STATUS_BEV_BIT] ? BEV_VECTOR_BASE : {ebase_o[31:12], 12'h000};
        // Dedicated interrupt vector only with Cause.IV
        if ((except_type_i == EXC_INT) && cause_i[CAUSE_IV_BIT]) begin
            vec_off = VEC_OFF_INT;
        end else begin
            vec_off = VEC_OFF_GENERAL;
        end
        exc_vector_o = (except_type_i == EXC_ERET) ? epc_i : (vec_base + vec_off);
    end

endmodule

/* logic/exc_commit_if.sv */
`timescale 1ns/10ps

interface exc_commit_if;
    import cp0_pkg::*;

    logic      take;
    exc_code_t exc_code;
    logic      bd_we;
    logic      bd;
    logic      eret;

    modport master (
        output take,
        output exc_code,
        output bd_we,
        output bd,
        output eret
    );

    modport slave (
        input take,
        input exc_code,
        input bd_we,
        input bd,
        input eret
    );

endinterface

/* project.f */
logic/cp0_pkg.sv
logic/exc_commit_if.sv
logic/cp0_timer.sv
logic/cp0_status_cause.sv
logic/cp0_exc_unit.sv
logic/cp0_vector.sv
logic/cp0_read_mux.sv
logic/cp0_top.sv
+incdir+tb
tb/cp0_tb.sv

/* tb/cp0_tb_model.svh */
`ifndef CP0_TB_MODEL_SVH
`define CP0_TB_MODEL_SVH

// Software-visible CP0 state
typedef struct packed {
    cp0_word_t count;
    cp0_word_t compare;
    logic      timer_int;
    cp0_word_t status;
    cp0_word_t cause;
    cp0_word_t epc;
    cp0_word_t badvaddr;
    cp0_word_t ebase;
} cp0_model_t;

cp0_model_t model_q;

function automatic cp0_model_t reset_state();
    cp0_model_t s;
    s        = '0;
    s.status = STATUS_RESET;
    s.ebase  = EBASE_RESET;
    return s;
endfunction

// State after the next edge given the inputs of this cycle
function automatic cp0_model_t next_state(input cp0_model_t s);
    cp0_model_t n;
    logic       is_exc;
    logic       new_epc;
    exc_code_t  code;
    n       = s;
    is_exc  = 1'b1;
    new_epc = ~s.status[STATUS_EXL_BIT];
    code    = EXCCODE_INT;

    n.count = (we && waddr == ADDR_COUNT) ? wdata : s.count + 32'd1;
    if (we && waddr == ADDR_COMPARE) begin
        n.compare   = wdata;
        n.timer_int = 1'b0;
    end else if (s.compare != '0 && s.count == s.compare) begin
        n.timer_int = 1'b1;
    end
    if (we && waddr == ADDR_STATUS) begin
        n.status = (s.status & ~STATUS_WMASK) | (wdata & STATUS_WMASK);
    end
    if (we && waddr == ADDR_CAUSE) begin
        n.cause = (s.cause & ~CAUSE_WMASK) | (wdata & CAUSE_WMASK);
    end
    if (we && waddr == ADDR_EPC) begin
        n.epc = wdata;
    end
    if (we && waddr == ADDR_EBASE) begin
        n.ebase = (s.ebase & ~EBASE_WMASK) | (wdata & EBASE_WMASK);
    end
    n.cause[15:10] = int_pins;

    case (except_type)
        EXC_INT:  new_epc = 1'b1;
        EXC_ADEL: begin
            code       = EXCCODE_ADEL;
            n.badvaddr = mem_addr;
        end
        EXC_ADES: begin
            code       = EXCCODE_ADES;
            n.badvaddr = mem_addr;
        end
        EXC_SYS:  code = EXCCODE_SYS;
        EXC_BP:   code = EXCCODE_BP;
        EXC_RI:   code = EXCCODE_RI;
        EXC_OV:   code = EXCCODE_OV;
        EXC_TR:   code = EXCCODE_TR;
        EXC_IADEL: begin
            code       = EXCCODE_ADEL;
            new_epc    = 1'b0;
            n.epc      = pc;
            n.badvaddr = pc;
        end
        default: begin
            is_exc  = 1'b0;
            new_epc = 1'b0;
        end
    endcase

    if (new_epc) begin
        n.epc       = in_delay_slot ? pc - 32'd4 : pc;
        n.cause[31] = in_delay_slot;
    end
    if (is_exc) begin
        n.status[1]  = 1'b1;
        n.cause[6:2] = code;
    end
    if (except_type == EXC_ERET) begin
        n.status[1] = 1'b0;
    end
    return n;
endfunction

function automatic cp0_word_t read_value(input cp0_model_t s, input cp0_addr_t a);
    case (a)
        ADDR_BADVADDR: return s.badvaddr;
        ADDR_COUNT:    return s.count;
        ADDR_COMPARE:  return s.compare;
        ADDR_STATUS:   return s.status;
        ADDR_CAUSE:    return s.cause;
        ADDR_EPC:      return s.epc;
        ADDR_PRID:     return PRID_VALUE;
        ADDR_EBASE:    return s.ebase;
        default:       return '0;
    endcase
endfunction

function automatic cp0_word_t expected_vector(input cp0_model_t s, input exc_type_t t);
    cp0_word_t base;
    if (t == EXC_ERET) begin
        return s.epc;
    end
    base = s.status[22] ? 32'hBFC0_0200 : (s.ebase & 32'hFFFF_F000);
    if (t == EXC_INT && s.cause[23]) begin
        return base + 32'h200;
    end
    return base + 32'h180;
endfunction

`endif

/* tb/cp0_tb.sv */
`timescale 1ns/10ps

module cp0_tb;
    import cp0_pkg::*;

    localparam cp0_word_t PRID_VALUE  = 32'h0001_8000;
    localparam cp0_word_t EBASE_RESET = 32'h8000_0000;

    localparam int N_MASK  = 6;
    localparam int N_TIMER = 3;
    localparam int N_EXC   = 40;
    localparam int N_ERET  = 8;
    localparam int N_PINS  = 16;
    localparam int TEST_STEPS = 1 + 4 * (1 + N_MASK) + N_TIMER + N_EXC + N_ERET + N_PINS;
    localparam int TIMEOUT_CYCLES = 40 * TEST_STEPS + 500;

    logic      clk;
    logic      rst;
    int_pins_t int_pins;
    logic      we;
    cp0_addr_t waddr;
    cp0_addr_t raddr;
    cp0_word_t wdata;
    exc_type_t except_type;
    cp0_word_t pc;
    cp0_word_t mem_addr;
    logic      in_delay_slot;

    cp0_word_t data_out;
    cp0_word_t vector_out;
    cp0_word_t status_out;
    cp0_word_t cause_out;
    cp0_word_t epc_out;
    logic      timer_int_out;

    logic [31:0] lfsr_q = 32'h484;
    int_pins_t   last_pins;
    int          errors;
    int          checks;
    int          cycles;

    exc_type_t exc_list [9] = '{EXC_INT, EXC_ADEL, EXC_ADES, EXC_SYS, EXC_BP,
                                EXC_RI, EXC_OV, EXC_TR, EXC_IADEL};

    `include "cp0_tb_model.svh"

    cp0_top #(
        .PRID_VALUE  (PRID_VALUE),
        .EBASE_RESET (EBASE_RESET)
    ) u_cp0_top (
        .clk             (clk),
        .rst             (rst),
        .int_i           (int_pins),
        .we_i            (we),
        .waddr_i         (waddr),
        .raddr_i         (raddr),
        .wdata_i         (wdata),
        .except_type_i   (except_type),
        .pc_i            (pc),
        .mem_addr_i      (mem_addr),
        .in_delay_slot_i (in_delay_slot),
        .data_o          (data_out),
        .exc_vector_o    (vector_out),
        .status_o        (status_out),
        .cause_o         (cause_out),
        .epc_o           (epc_out),
        .timer_int_o     (timer_int_out)
    );

    always #10 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic cp0_word_t rand_bits(input int n);
        cp0_word_t v;
        logic      fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_word(input string name, input cp0_word_t exp, input cp0_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic finish_run();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // One cycle of stimulus with random pins
    task automatic drive_step(input logic w, input cp0_addr_t wa, input cp0_word_t wd,
                              input cp0_addr_t ra, input exc_type_t t,
                              input cp0_word_t pcv, input cp0_word_t memv, input logic ds);
        @(posedge clk);
        last_pins = int_pins_t'(rand_bits(6));
        we            <= w;
        waddr         <= wa;
        wdata         <= wd;
        raddr         <= ra;
        except_type   <= t;
        pc            <= pcv;
        mem_addr      <= memv;
        in_delay_slot <= ds;
        int_pins      <= last_pins;
    endtask

    task automatic write_reg(input cp0_addr_t a, input cp0_word_t d);
        drive_step(1'b1, a, d, a, EXC_NONE, '0, '0, 1'b0);
    endtask

    task automatic read_reg(input cp0_addr_t a);
        drive_step(1'b0, '0, '0, a, EXC_NONE, '0, '0, 1'b0);
    endtask

    task automatic read_expect(input cp0_addr_t a, input cp0_word_t exp, input string name);
        read_reg(a);
        @(negedge clk);
        check_word(name, exp, data_out);
    endtask

    task automatic reset_values();
        read_expect(ADDR_STATUS, STATUS_RESET, "data_o Status");
        read_expect(ADDR_EBASE, EBASE_RESET, "data_o EBase");
        read_expect(ADDR_PRID, PRID_VALUE, "data_o PRId");
        read_expect(ADDR_BADVADDR, '0, "data_o BadVAddr");
        read_expect(ADDR_COMPARE, '0, "data_o Compare");
        read_expect(ADDR_EPC, '0, "data_o EPC");
        read_expect({5'd16, 3'd0}, '0, "data_o unused");
        read_reg(ADDR_COUNT);
        read_reg(ADDR_CAUSE);
        @(negedge clk);
        check_bit("timer_int_o", 1'b0, timer_int_out);
    endtask

    task automatic masked_writes();
        cp0_addr_t regs [4] = '{ADDR_STATUS, ADDR_CAUSE, ADDR_EPC, ADDR_EBASE};
        for (int r = 0; r < 4; r++) begin
            write_reg(regs[r], '1);
            read_reg(regs[r]);
            for (int i = 0; i < N_MASK; i++) begin
                write_reg(regs[r], rand_bits(32));
                read_reg(regs[r]);
            end
        end
    endtask

    task automatic timer_match();
        cp0_word_t c;
        int        edges;
        for (int t = 0; t < N_TIMER; t++) begin
            c = 32'd2 + rand_bits(4);
            // Park Count far from C so no match fires before the restart
            write_reg(ADDR_COUNT, 32'h8000_0000);
            write_reg(ADDR_COMPARE, c);
            write_reg(ADDR_COUNT, '0);
            // Count write lands at this edge
            read_reg(ADDR_COUNT);
            edges = 0;
            @(negedge clk);
            while (!timer_int_out && edges < 64) begin
                @(negedge clk);
                edges++;
            end
            check_word("timer edges", c + 32'd1, cp0_word_t'(edges));
            read_reg(ADDR_COUNT);
            @(negedge clk);
            check_bit("timer_int_o", 1'b1, timer_int_out);
            write_reg(ADDR_COMPARE, 32'hFFFF_0000);
            read_reg(ADDR_COMPARE);
            @(negedge clk);
            check_bit("timer_int_o", 1'b0, timer_int_out);
        end
    endtask

    task automatic exception_entry();
        exc_type_t t;
        cp0_word_t pcv;
        cp0_word_t memv;
        logic      ds;
        for (int i = 0; i < N_EXC; i++) begin
            // Random EXL, BEV, IV and EBase ahead of the exception
            write_reg(ADDR_STATUS, rand_bits(32));
            write_reg(ADDR_CAUSE, rand_bits(32));
            write_reg(ADDR_EBASE, rand_bits(32));
            t    = exc_list[rand_bits(4) % 9];
            pcv  = rand_bits(32);
            memv = rand_bits(32);
            ds   = rand_bits(1) != '0;
            drive_step(1'b0, '0, '0, ADDR_EPC, t, pcv, memv, ds);
            read_reg(ADDR_EPC);
            read_reg(ADDR_BADVADDR);
            read_reg(ADDR_CAUSE);
            read_reg(ADDR_STATUS);
        end
    endtask

    task automatic eret_return();
        cp0_word_t epcv;
        for (int i = 0; i < N_ERET; i++) begin
            epcv = rand_bits(32);
            write_reg(ADDR_EPC, epcv);
            write_reg(ADDR_STATUS, rand_bits(32) | 32'h2);
            drive_step(1'b0, '0, '0, ADDR_STATUS, EXC_ERET, rand_bits(32), '0, 1'b0);
            @(negedge clk);
            check_word("exc_vector_o", epcv, vector_out);
            read_reg(ADDR_STATUS);
            @(negedge clk);
            check_bit("status_o EXL", 1'b0, status_out[STATUS_EXL_BIT]);
        end
    endtask

    task automatic int_pin_sampling();
        int_pins_t pins;
        for (int i = 0; i < N_PINS; i++) begin
            read_reg(ADDR_CAUSE);
            pins = last_pins;
            read_reg(ADDR_CAUSE);
            @(negedge clk);
            check_word("cause_o IP7..2", cp0_word_t'(pins), cp0_word_t'(cause_out[15:10]));
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            model_q <= reset_state();
        end else begin
            model_q <= next_state(model_q);
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            check_word("data_o", read_value(model_q, raddr), data_out);
            check_word("exc_vector_o", expected_vector(model_q, except_type), vector_out);
            check_word("status_o", model_q.status, status_out);
            check_word("cause_o", model_q.cause, cause_out);
            check_word("epc_o", model_q.epc, epc_out);
            check_bit("timer_int_o", model_q.timer_int, timer_int_out);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish");
            errors = errors + 1;
            finish_run();
        end
    end

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        int_pins      = '0;
        we            = 1'b0;
        waddr         = '0;
        raddr         = '0;
        wdata         = '0;
        except_type   = EXC_NONE;
        pc            = '0;
        mem_addr      = '0;
        in_delay_slot = 1'b0;
        last_pins     = '0;
        errors        = 0;
        checks        = 0;
        cycles        = 0;

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        reset_values();
        masked_writes();
        timer_match();
        exception_entry();
        eret_return();
        int_pin_sampling();

        read_reg(ADDR_STATUS);
        @(negedge clk);
        @(posedge clk);
        finish_run();
    end

endmodule
